// ==== src/coreDefs.sv ====
package coreDefs;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int XLEN       = 32;  // Data and address width
  localparam int REG_ADDR_W = 4;
  localparam int NUM_REGS   = 16;
  localparam int OPC_W      = 5;
  localparam int IMM_W      = 16;  // Immediate field before extension

  // ====================================================================
  // Instruction field positions
  // ====================================================================
  localparam int OPC_LSB   = 27;  // Opcode in bits 31..27
  localparam int IMM_BIT   = 26;  // Operand B comes from the immediate
  localparam int RD_LSB    = 22;
  localparam int RS1_LSB   = 18;
  localparam int RS2_LSB   = 14;
  localparam int MOD_U_BIT = 16;  // Zero-filled immediate
  localparam int MOD_H_BIT = 17;  // Immediate in the upper half
  localparam int OFFSET_W  = 27;  // Branch offset in words

  // Opcode encodings, anything else decodes as nop
  typedef enum logic [OPC_W-1:0] {
    OP_ADD = 5'b00000,
    OP_SUB = 5'b00001,
    OP_CMP = 5'b00101,
    OP_AND = 5'b00110,
    OP_OR  = 5'b00111,
    OP_NOT = 5'b01000,
    OP_MOV = 5'b01001,
    OP_LSL = 5'b01010,
    OP_LSR = 5'b01011,
    OP_ASR = 5'b01100,
    OP_NOP = 5'b01101,
    OP_BEQ = 5'b10000,
    OP_BGT = 5'b10001,
    OP_B   = 5'b10010
  } opcodeT;

  // ALU operation carried down the pipe
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_CMP,
    ALU_AND,
    ALU_OR,
    ALU_NOT,
    ALU_MOV,
    ALU_LSL,
    ALU_LSR,
    ALU_ASR,
    ALU_NONE
  } aluOpT;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_GT,
    BR_ALWAYS
  } brKindT;

endpackage

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import coreDefs::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          progWr,
  input  logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
  input  logic [XLEN-1:0]               progData,
  input  logic                          taken,
  input  logic [XLEN-1:0]               target,
  output logic [XLEN-1:0]               pc,
  output logic [XLEN-1:0]               instr
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [XLEN-1:0] imem [IMEM_DEPTH];
  logic [AW-1:0]   wordAddr;

  // Program load, one word per strobe
  always_ff @(posedge clk) begin
    if (progWr) begin
      imem[progAddr] <= progData;
    end
  end

  assign wordAddr = pc[AW+1:2];  // Byte PC to word index
  assign instr    = imem[wordAddr];

  // Program counter
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (taken) begin
      pc <= target;  // Redirect from execute
    end else begin
      pc <= pc + XLEN'(4);
    end
  end

endmodule

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit import coreDefs::*; (
  input  logic [XLEN-1:0]       instr,
  input  logic [XLEN-1:0]       pc,
  output logic [REG_ADDR_W-1:0] rdAddr1,
  output logic [REG_ADDR_W-1:0] rdAddr2,
  output logic [REG_ADDR_W-1:0] rd,
  output aluOpT                 aluOp,
  output brKindT                brKind,
  output logic                  immSel,
  output logic                  writeEn,
  output logic [XLEN-1:0]       imm,
  output logic [XLEN-1:0]       branchTarget
);

  opcodeT              opcode;
  logic                isAluOp;
  logic [IMM_W-1:0]    imm16;
  logic                modU;
  logic                modH;
  logic [OFFSET_W-1:0] offset;
  logic [XLEN-1:0]     offsetBytes;

  assign opcode  = opcodeT'(instr[XLEN-1:OPC_LSB]);
  assign rd      = instr[RD_LSB +: REG_ADDR_W];
  assign rdAddr1 = instr[RS1_LSB +: REG_ADDR_W];
  assign rdAddr2 = instr[RS2_LSB +: REG_ADDR_W];

  // Opcode to controls
  always_comb begin
    aluOp  = ALU_NONE;
    brKind = BR_NONE;
    case (opcode)
      OP_ADD:  aluOp = ALU_ADD;
      OP_SUB:  aluOp = ALU_SUB;
      OP_CMP:  aluOp = ALU_CMP;
      OP_AND:  aluOp = ALU_AND;
      OP_OR:   aluOp = ALU_OR;
      OP_NOT:  aluOp = ALU_NOT;
      OP_MOV:  aluOp = ALU_MOV;
      OP_LSL:  aluOp = ALU_LSL;
      OP_LSR:  aluOp = ALU_LSR;
      OP_ASR:  aluOp = ALU_ASR;
      OP_BEQ:  brKind = BR_EQ;
      OP_BGT:  brKind = BR_GT;
      OP_B:    brKind = BR_ALWAYS;
      default: aluOp = ALU_NONE;  // nop and every dropped opcode
    endcase
  end

  assign isAluOp = (aluOp != ALU_NONE);
  assign writeEn = isAluOp && (aluOp != ALU_CMP);  // cmp only touches flags
  assign immSel  = isAluOp && instr[IMM_BIT];

  // Immediate extension with the u and h modifiers
  assign imm16 = instr[IMM_W-1:0];
  assign modU  = instr[MOD_U_BIT];
  assign modH  = instr[MOD_H_BIT];

  always_comb begin
    case ({modH, modU})
      2'b01:   imm = {{(XLEN-IMM_W){1'b0}}, imm16};
      2'b10:   imm = {imm16, {(XLEN-IMM_W){1'b0}}};
      default: imm = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};  // Plain or both set
    endcase
  end

  // Word offset, sign extended and scaled to bytes
  assign offset       = instr[OFFSET_W-1:0];
  assign offsetBytes  = {{(XLEN-OFFSET_W-2){offset[OFFSET_W-1]}}, offset, 2'b00};
  assign branchTarget = pc + offsetBytes;

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile import coreDefs::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rdAddr1,
  input  logic [REG_ADDR_W-1:0] rdAddr2,
  input  logic                  wrEn,
  input  logic [REG_ADDR_W-1:0] wrAddr,
  input  logic [XLEN-1:0]       wrData,
  output logic [XLEN-1:0]       rdData1,
  output logic [XLEN-1:0]       rdData2
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Reads see the old value during a write, no bypass
  assign rdData1 = regs[rdAddr1];
  assign rdData2 = regs[rdAddr2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import coreDefs::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  aluOpT           aluOp,
  output logic [XLEN-1:0] result,
  output logic            cmpGt,
  output logic            cmpEq
);

  localparam int SH_W = $clog2(XLEN);

  logic            subMode;
  logic [XLEN-1:0] bOperand;
  logic [XLEN-1:0] sum;
  logic            overflow;
  logic            lessThan;
  logic            equal;
  logic            isCmp;
  logic [SH_W-1:0] shamt;
  logic            shiftSat;
  logic [XLEN-1:0] shlRes;
  logic [XLEN-1:0] shrRes;
  logic [XLEN-1:0] sraRes;

  // ====================================================================
  // Shared adder/subtractor and compare
  // ====================================================================
  assign subMode  = (aluOp == ALU_SUB) || (aluOp == ALU_CMP);
  assign bOperand = subMode ? ~b : b;
  assign sum      = a + bOperand + XLEN'(subMode);  // Two's complement subtract

  // Signed a < b from the difference sign, corrected for overflow
  assign overflow = (a[XLEN-1] ^ b[XLEN-1]) & (sum[XLEN-1] ^ a[XLEN-1]);
  assign lessThan = sum[XLEN-1] ^ overflow;
  assign equal    = (a == b);

  assign isCmp = (aluOp == ALU_CMP);
  assign cmpEq = isCmp && equal;
  assign cmpGt = isCmp && !lessThan && !equal;

  // ====================================================================
  // Barrel shifter
  // ====================================================================
  assign shamt    = b[SH_W-1:0];
  assign shiftSat = |b[XLEN-1:SH_W];  // Amount of 32 or more

  assign shlRes = shiftSat ? '0 : (a << shamt);
  assign shrRes = shiftSat ? '0 : (a >> shamt);

  always_comb begin
    if (shiftSat) begin
      sraRes = {XLEN{a[XLEN-1]}};  // All sign bits
    end else begin
      sraRes = $signed(a) >>> shamt;
    end
  end

  // Result select
  always_comb begin
    case (aluOp)
      ALU_ADD,
      ALU_SUB,
      ALU_CMP: result = sum;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_NOT: result = ~b;  // Unary ops take operand B
      ALU_MOV: result = b;
      ALU_LSL: result = shlRes;
      ALU_LSR: result = shrRes;
      ALU_ASR: result = sraRes;
      default: result = '0;
    endcase
  end

endmodule

// ==== src/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit import coreDefs::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            isCmp,
  input  logic            cmpGt,
  input  logic            cmpEq,
  input  brKindT          brKind,
  input  logic [XLEN-1:0] branchTarget,
  output logic            taken,
  output logic [XLEN-1:0] target,
  output logic            flagGt,
  output logic            flagEq
);

  // Flags change only on cmp, visible to the next instruction in execute
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      flagGt <= 1'b0;
      flagEq <= 1'b0;
    end else if (isCmp) begin
      flagGt <= cmpGt;
      flagEq <= cmpEq;
    end
  end

  always_comb begin
    case (brKind)
      BR_EQ:     taken = flagEq;
      BR_GT:     taken = flagGt;
      BR_ALWAYS: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  assign target = branchTarget;  // PC-relative, already computed in decode

endmodule

// ==== src/simpleRiscCore.sv ====
`timescale 1ns/1ps

module simpleRiscCore import coreDefs::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          progWr,
  input  logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
  input  logic [XLEN-1:0]               progData,
  output logic                          wbValid,
  output logic [REG_ADDR_W-1:0]         wbReg,
  output logic [XLEN-1:0]               wbData,
  output logic                          flagGt,
  output logic                          flagEq
);

  localparam logic [XLEN-1:0] NOP_INSTR = {OP_NOP, {OPC_LSB{1'b0}}};

  logic [XLEN-1:0]       ifPc;
  logic [XLEN-1:0]       ifInstr;
  logic                  brTaken;
  logic [XLEN-1:0]       brTarget;
  logic [XLEN-1:0]       ofPc;
  logic [XLEN-1:0]       ofInstr;
  logic [REG_ADDR_W-1:0] ofRdAddr1;
  logic [REG_ADDR_W-1:0] ofRdAddr2;
  logic [REG_ADDR_W-1:0] ofRd;
  aluOpT                 ofAluOp;
  brKindT                ofBrKind;
  logic                  ofImmSel;
  logic                  ofWriteEn;
  logic [XLEN-1:0]       ofImm;
  logic [XLEN-1:0]       ofBranchTarget;
  logic [XLEN-1:0]       ofRs1Val;
  logic [XLEN-1:0]       ofRs2Val;
  logic [XLEN-1:0]       exRs1Val;
  logic [XLEN-1:0]       exRs2Val;
  logic [XLEN-1:0]       exImm;
  logic [XLEN-1:0]       exBranchTarget;
  logic [REG_ADDR_W-1:0] exRd;
  aluOpT                 exAluOp;
  brKindT                exBrKind;
  logic                  exImmSel;
  logic                  exWriteEn;
  logic [XLEN-1:0]       exOpB;
  logic [XLEN-1:0]       exResult;
  logic                  exCmpGt;
  logic                  exCmpEq;
  logic                  rwWriteEn;
  logic [REG_ADDR_W-1:0] rwRd;
  logic [XLEN-1:0]       rwResult;

  // ====================================================================
  // Fetch
  // ====================================================================
  fetchUnit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk(clk), .rst(rst), .progWr(progWr), .progAddr(progAddr), .progData(progData),
    .taken(brTaken), .target(brTarget), .pc(ifPc), .instr(ifInstr)
  );

  // IF/OF register, reset to a nop word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ofInstr <= NOP_INSTR;
    end else begin
      ofInstr <= ifInstr;
    end
  end

  always_ff @(posedge clk) begin
    ofPc <= ifPc;
  end

  // ====================================================================
  // Operand fetch
  // ====================================================================
  decodeUnit u_decode (
    .instr(ofInstr), .pc(ofPc), .rdAddr1(ofRdAddr1), .rdAddr2(ofRdAddr2), .rd(ofRd),
    .aluOp(ofAluOp), .brKind(ofBrKind), .immSel(ofImmSel), .writeEn(ofWriteEn),
    .imm(ofImm), .branchTarget(ofBranchTarget)
  );

  regFile u_regs (
    .clk(clk), .rst(rst), .rdAddr1(ofRdAddr1), .rdAddr2(ofRdAddr2),
    .wrEn(rwWriteEn), .wrAddr(rwRd), .wrData(rwResult),
    .rdData1(ofRs1Val), .rdData2(ofRs2Val)
  );

  // OF/EX register, controls cleared to nop
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      exAluOp   <= ALU_NONE;
      exBrKind  <= BR_NONE;
      exImmSel  <= 1'b0;
      exWriteEn <= 1'b0;
    end else begin
      exAluOp   <= ofAluOp;
      exBrKind  <= ofBrKind;
      exImmSel  <= ofImmSel;
      exWriteEn <= ofWriteEn;
    end
  end

  always_ff @(posedge clk) begin
    exRs1Val       <= ofRs1Val;
    exRs2Val       <= ofRs2Val;
    exImm          <= ofImm;
    exBranchTarget <= ofBranchTarget;
    exRd           <= ofRd;
  end

  // ====================================================================
  // Execute
  // ====================================================================
  assign exOpB = exImmSel ? exImm : exRs2Val;

  aluUnit u_alu (
    .a(exRs1Val), .b(exOpB), .aluOp(exAluOp),
    .result(exResult), .cmpGt(exCmpGt), .cmpEq(exCmpEq)
  );

  // Resolves in execute, the two younger instructions still complete
  branchUnit u_branch (
    .clk(clk), .rst(rst), .isCmp(exAluOp == ALU_CMP), .cmpGt(exCmpGt), .cmpEq(exCmpEq),
    .brKind(exBrKind), .branchTarget(exBranchTarget),
    .taken(brTaken), .target(brTarget), .flagGt(flagGt), .flagEq(flagEq)
  );

  // EX/RW register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rwWriteEn <= 1'b0;
    end else begin
      rwWriteEn <= exWriteEn;
    end
  end

  always_ff @(posedge clk) begin
    rwRd     <= exRd;
    rwResult <= exResult;
  end

  // Writeback stream mirrors the register file write port
  assign wbValid = rwWriteEn;
  assign wbReg   = rwRd;
  assign wbData  = rwResult;

endmodule

// ==== tb/simpleRiscCore_chk.sv ====
`timescale 1ns/1ps

module simpleRiscCoreChk import coreDefs::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  wbValid,
  input logic [REG_ADDR_W-1:0] wbReg,
  input logic                  flagGt,
  input logic                  flagEq,
  input logic [XLEN-1:0]       ofInstr
);

  logic [OPC_W-1:0]      ofOpc;
  logic [REG_ADDR_W-1:0] ofRd;
  logic                  ofWrites;

  assign ofOpc = ofInstr[XLEN-1:OPC_LSB];
  assign ofRd  = ofInstr[RD_LSB +: REG_ADDR_W];

  // Opcodes that retire through the writeback stream
  assign ofWrites = ofOpc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT,
                                  OP_MOV, OP_LSL, OP_LSR, OP_ASR};

  // ====================================================================
  // Reset behaviour
  // ====================================================================
  property quietInReset;
    @(posedge clk) rst |-> !wbValid && !flagGt && !flagEq;
  endproperty

  property quietAfterReset;
    @(posedge clk) $fell(rst) |-> !wbValid && !flagGt && !flagEq;
  endproperty

  aReset: assert property (quietInReset)
    else $error("Writeback or flags active while in reset");
  aRelease: assert property (quietAfterReset)
    else $error("Writeback or flags active in the first cycle after reset");

  // ====================================================================
  // Writeback and flags while running
  // ====================================================================
  // Decoded instruction retires two cycles after it leaves operand fetch
  aWbRetire: assert property (@(posedge clk) disable iff (rst)
      $past(ofWrites, 2) |-> wbValid && wbReg == $past(ofRd, 2))
    else $error("Register-writing instruction did not retire to its rd");

  aNoStrayWb: assert property (@(posedge clk) disable iff (rst)
      !$past(ofWrites, 2) |-> !wbValid)
    else $error("Writeback raised for nop, cmp or branch");

  // Flags move on cmp only
  aFlagsHold: assert property (@(posedge clk) disable iff (rst)
      $past(ofOpc, 2) != OP_CMP |-> $stable({flagGt, flagEq}))
    else $error("Flags changed without a cmp");

endmodule

// ==== tb/simpleRiscCore_tb.sv ====
`timescale 1ns/1ps

module simpleRiscCore_tb import coreDefs::*;;

  localparam int IMEM_DEPTH = 256;
  localparam int AW         = $clog2(IMEM_DEPTH);

  typedef struct packed {
    logic                  gt;
    logic                  eq;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       val;
  } expT;

  localparam logic [XLEN-1:0] NOP_W = {OP_NOP, 27'd0};

  logic                  clk;
  logic                  rst;
  logic                  progWr;
  logic [AW-1:0]         progAddr;
  logic [XLEN-1:0]       progData;
  logic                  wbValid;
  logic [REG_ADDR_W-1:0] wbReg;
  logic [XLEN-1:0]       wbData;
  logic                  flagGt;
  logic                  flagEq;

  logic [XLEN-1:0] prog[$];
  expT             expQ[$];
  int              expTotal;
  int              wbCount;
  int              checkCount;
  int              errCount;
  int              limitCycles;

  simpleRiscCore #(.IMEM_DEPTH(IMEM_DEPTH)) i_dut (
    .clk(clk), .rst(rst), .progWr(progWr), .progAddr(progAddr), .progData(progData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .flagGt(flagGt), .flagEq(flagEq)
  );

  bind simpleRiscCore simpleRiscCoreChk u_chk (
    .clk(clk), .rst(rst), .wbValid(wbValid), .wbReg(wbReg), .flagGt(flagGt),
    .flagEq(flagEq), .ofInstr(ofInstr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // Instruction encoders and program builder
  // ====================================================================
  function automatic logic [XLEN-1:0] aluReg(logic [4:0] op, int rd, int rs1, int rs2);
    return {op, 1'b0, rd[3:0], rs1[3:0], rs2[3:0], 14'd0};
  endfunction

  function automatic logic [XLEN-1:0] aluImm(logic [4:0] op, int rd, int rs1,
                                             logic [15:0] v, logic h, logic u);
    return {op, 1'b1, rd[3:0], rs1[3:0], h, u, v};
  endfunction

  function automatic logic [XLEN-1:0] branchWord(logic [4:0] op, int off);
    return {op, off[26:0]};
  endfunction

  task automatic putAlu(logic [XLEN-1:0] w);
    prog.push_back(w);
    prog.push_back(NOP_W);  // Two nops keep the result visible to the next one
    prog.push_back(NOP_W);
  endtask

  // Branch six words ahead, two delay slots, three skipped words, two nops at target
  task automatic putBranch(logic [4:0] op);
    prog.push_back(branchWord(op, 6));
    prog.push_back(aluImm(OP_MOV, 11, 0, 16'($urandom), 1'b0, 1'b0));
    prog.push_back(aluImm(OP_MOV, 12, 0, 16'($urandom), 1'b0, 1'b1));
    for (int i = 0; i < 3; i++) begin
      prog.push_back(aluImm(OP_MOV, 13, 0, 16'($urandom), 1'b0, 1'b0));
    end
    prog.push_back(NOP_W);
    prog.push_back(NOP_W);
  endtask

  task automatic buildProgram();
    logic [4:0] aluOps[6];
    logic [4:0] shOps[3];
    int         amts[6];
    aluOps = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_MOV};
    shOps  = '{OP_LSL, OP_LSR, OP_ASR};
    amts   = '{0, 31, 32, 45, 1, 7};
    for (int r = 1; r <= 8; r++) begin  // Every modifier combination
      putAlu(aluImm(OP_MOV, r, 0, 16'($urandom), r[1], r[0]));
    end
    putAlu(aluImm(OP_MOV, 15, 0, 16'h8001, 1'b1, 1'b0));  // Negative value for asr
    for (int rep = 0; rep < 2; rep++) begin
      foreach (aluOps[k]) begin
        putAlu(aluReg(aluOps[k], 9 + $urandom % 6, 1 + $urandom % 8, 1 + $urandom % 8));
        putAlu(aluImm(aluOps[k], 9 + $urandom % 6, 1 + $urandom % 8, 16'($urandom),
                      1'($urandom), 1'($urandom)));
      end
    end
    // Shifts by fixed, random and oversized amounts
    foreach (shOps[k]) begin
      foreach (amts[j]) begin
        putAlu(aluImm(shOps[k], 10, 15, 16'(amts[j]), 1'b0, 1'b1));
      end
      putAlu(aluImm(shOps[k], 10, 1 + $urandom % 8, 16'($urandom % 32), 1'b0, 1'b1));
      putAlu(aluReg(shOps[k], 10, 15, 1 + $urandom % 8));
    end
    putAlu(aluImm(OP_MOV, 14, 0, 16'd100, 1'b0, 1'b0));
    prog.push_back(aluReg(OP_CMP, 0, 4, 4));  // Equal, beq taken
    putBranch(OP_BEQ);
    prog.push_back(aluImm(OP_CMP, 0, 14, 16'd5, 1'b0, 1'b0));  // Greater, bgt taken
    putBranch(OP_BGT);
    prog.push_back(aluImm(OP_CMP, 0, 14, 16'd500, 1'b0, 1'b0));  // Both fall through
    putBranch(OP_BEQ);
    putBranch(OP_BGT);
    putBranch(OP_B);
    prog.push_back(aluReg(OP_CMP, 0, 1, 2));
    putBranch(OP_BGT);
    prog.push_back(branchWord(OP_B, 0));  // Park on a self loop
    prog.push_back(NOP_W);
    prog.push_back(NOP_W);
  endtask

  // ====================================================================
  // Instruction set model, in fetch order with two delay slots
  // ====================================================================
  task automatic runModel(output int steps);
    logic [XLEN-1:0] regs[NUM_REGS];
    logic [XLEN-1:0] pc, ins, a, b, res, imm, tgt, pendTgt;
    logic [4:0]      opc;
    logic            gt, eq, wr, takeBr;
    int              cd;
    foreach (regs[i]) regs[i] = '0;
    pc      = '0;
    pendTgt = '0;
    gt      = 1'b0;
    eq      = 1'b0;
    cd      = 0;
    steps   = 0;
    while (steps < 4 * IMEM_DEPTH) begin
      ins = (pc / 4 < prog.size()) ? prog[pc / 4] : NOP_W;
      opc = ins[31:27];
      if (opc == OP_B && ins[26:0] == 27'd0) break;
      case (ins[17:16])
        2'b01:   imm = {16'd0, ins[15:0]};
        2'b10:   imm = {ins[15:0], 16'd0};
        default: imm = {{16{ins[15]}}, ins[15:0]};
      endcase
      a   = regs[ins[21:18]];
      b   = ins[26] ? imm : regs[ins[17:14]];
      wr  = 1'b1;
      res = '0;
      case (opc)
        OP_ADD: res = a + b;
        OP_SUB: res = a - b;
        OP_AND: res = a & b;
        OP_OR:  res = a | b;
        OP_NOT: res = ~b;
        OP_MOV: res = b;
        OP_LSL: res = (b >= 32) ? '0 : a << b[4:0];
        OP_LSR: res = (b >= 32) ? '0 : a >> b[4:0];
        OP_ASR: res = (b >= 32) ? {XLEN{a[31]}} : XLEN'($signed(a) >>> b[4:0]);
        default: wr = 1'b0;
      endcase
      if (wr) begin
        regs[ins[25:22]] = res;
        expQ.push_back('{gt: gt, eq: eq, rd: ins[25:22], val: res});
      end
      if (opc == OP_CMP) begin
        gt = $signed(a) > $signed(b);
        eq = (a == b);
      end
      tgt    = pc + {{3{ins[26]}}, ins[26:0], 2'b00};
      takeBr = (opc == OP_BEQ && eq) || (opc == OP_BGT && gt) || opc == OP_B;
      if (cd > 0) begin
        cd--;
        pc = (cd == 0) ? pendTgt : pc + 4;  // Redirect after the second delay slot
      end else begin
        pc = pc + 4;
      end
      if (takeBr) begin
        cd      = 2;
        pendTgt = tgt;
      end
      steps++;
    end
  endtask

  // Writeback compare, on the falling edge where outputs are stable
  always @(negedge clk) begin
    expT e;
    if (!rst && wbValid) begin
      wbCount++;
      checkCount++;
      if (expQ.size() == 0) begin
        errCount++;
        $display("Unexpected writeback to r%0d at %0t with nothing left to retire",
                 wbReg, $time);
      end else begin
        e = expQ.pop_front();
        assert (wbReg == e.rd && wbData == e.val && flagGt == e.gt && flagEq == e.eq)
        else begin
          errCount++;
          $display("ERROR at %0t: r%0d=%h gt=%b eq=%b, expected r%0d=%h gt=%b eq=%b",
                   $time, wbReg, wbData, flagGt, flagEq, e.rd, e.val, e.gt, e.eq);
        end
      end
    end
  end

  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("Timeout: the core did not retire all expected writebacks in time");
    $display("Something failed");
    $finish;
  end

  initial begin
    int steps;
    rst         = 1'b1;
    progWr      = 1'b0;
    progAddr    = '0;
    progData    = '0;
    wbCount     = 0;
    checkCount  = 0;
    errCount    = 0;
    limitCycles = 0;
    void'($urandom(27726));  // One seed for the whole run
    buildProgram();
    runModel(steps);
    expTotal    = expQ.size();
    limitCycles = IMEM_DEPTH + 16 + steps + 50;
    for (int i = 0; i < IMEM_DEPTH; i++) begin  // Memory ignores reset
      @(negedge clk);
      progWr   = 1'b1;
      progAddr = AW'(i);
      progData = (i < prog.size()) ? prog[i] : {OP_NOP, 27'(i)};
    end
    @(negedge clk);
    progWr = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    while (expQ.size() != 0) @(negedge clk);
    repeat (10) @(negedge clk);  // Catch any late extra writeback
    checkCount++;
    assert (wbCount == expTotal)
    else begin
      errCount++;
      $display("ERROR at %0t: %0d writebacks, expected %0d", $time, wbCount, expTotal);
    end
    $display("Checks: %0d, errors: %0d, writebacks: %0d", checkCount, errCount, wbCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== simpleRiscCore.f ====
src/coreDefs.sv
src/fetchUnit.sv
src/decodeUnit.sv
src/regFile.sv
src/aluUnit.sv
src/branchUnit.sv
src/simpleRiscCore.sv
tb/simpleRiscCore_chk.sv
tb/simpleRiscCore_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module simpleRiscCore_tb -f simpleRiscCore.f -o simv

# The simulator may stop on an assertion, the log search decides the result
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
exit 1
